//--- bench/raystore_tb.sv
`default_nettype none

module raystore_tb
	import raystore_pkg::*;
();

	localparam int PERIOD = 100;
	localparam int NUM_ROWS = 14;
	localparam int TAG_W = NODE_ID_W;
	localparam logic [31:0] SEED = 32'heda3_71b9;
	// memory fill, then at most twenty cycles per table row
	localparam int TIMEOUT = (RAM_DEPTH + 8 + NUM_ROWS * 20) * PERIOD;

	typedef struct {
		logic                load;
		logic [NUM_REQ-1:0]  valid;
		logic [RAY_ID_W-1:0] ray_id;
		logic [TAG_W-1:0]    tag;
		axis_e               axis;
		logic [NUM_REQ-1:0]  out_rdy;
		int                  hold;
	} row_t;

	typedef struct {
		logic [RAY_ID_W-1:0] ray_id;
		logic [TAG_W-1:0]    tag;
		axis_e               axis;
		logic [RAY_W-1:0]    ray;
	} exp_t;

	logic clk;
	logic arst_n;
	logic [NUM_REQ-1:0] req_valid;
	logic [NUM_REQ-1:0] req_ready;
	logic [RAY_ID_W-1:0] req_id [NUM_REQ];
	logic [TAG_W-1:0] req_tag [NUM_REQ];
	axis_e req_axis [NUM_REQ];
	logic [NUM_REQ-1:0] out_valid;
	logic [NUM_REQ-1:0] out_ready;
	logic [RAY_ID_W-1:0] res_id [NUM_REQ];
	logic [TAG_W-1:0] res_tag [NUM_REQ];
	logic [WORD_W-1:0] res_org [NUM_REQ];
	logic [WORD_W-1:0] res_dir [NUM_REQ];
	logic [RAY_W-1:0] res_ray [NUM_REQ];
	logic load_en;
	logic [RAY_ID_W-1:0] load_addr;
	logic [RAY_W-1:0] load_data;

	logic [RAY_W-1:0] ref_mem [RAM_DEPTH];
	exp_t exp_q [NUM_REQ][$];
	row_t rows [NUM_ROWS];
	logic [NUM_REQ-1:0] served;
	int seed;
	int checks;
	int errors;

	tb_clock #(.PERIOD(PERIOD), .RESET_CYCLES(3)) u_clock (
		.clk(clk),
		.arst_n(arst_n)
	);

	raystore DUT (
		.clk(clk),
		.arst_n(arst_n),
		.trav0_valid(req_valid[0]),
		.trav0_ready(req_ready[0]),
		.trav0_ray_id(req_id[0]),
		.trav0_node_id(req_tag[0]),
		.trav0_axis(req_axis[0]),
		.trav1_valid(req_valid[1]),
		.trav1_ready(req_ready[1]),
		.trav1_ray_id(req_id[1]),
		.trav1_node_id(req_tag[1]),
		.trav1_axis(req_axis[1]),
		.lcache_valid(req_valid[2]),
		.lcache_ready(req_ready[2]),
		.lcache_ray_id(req_id[2]),
		.lcache_tri_id(req_tag[2]),
		.list_valid(req_valid[3]),
		.list_ready(req_ready[3]),
		.list_ray_id(req_id[3]),
		.trav0_out_valid(out_valid[0]),
		.trav0_out_ready(out_ready[0]),
		.trav0_out_ray_id(res_id[0]),
		.trav0_out_node_id(res_tag[0]),
		.trav0_out_axis_origin(res_org[0]),
		.trav0_out_axis_dir(res_dir[0]),
		.trav1_out_valid(out_valid[1]),
		.trav1_out_ready(out_ready[1]),
		.trav1_out_ray_id(res_id[1]),
		.trav1_out_node_id(res_tag[1]),
		.trav1_out_axis_origin(res_org[1]),
		.trav1_out_axis_dir(res_dir[1]),
		.lcache_out_valid(out_valid[2]),
		.lcache_out_ready(out_ready[2]),
		.lcache_out_ray_id(res_id[2]),
		.lcache_out_tri_id(res_tag[2]),
		.lcache_out_ray(res_ray[2]),
		.list_out_valid(out_valid[3]),
		.list_out_ready(out_ready[3]),
		.list_out_ray_id(res_id[3]),
		.list_out_ray(res_ray[3]),
		.load_en(load_en),
		.load_addr(load_addr),
		.load_data(load_data)
	);

	function automatic logic [RAY_W-1:0] random_ray();
		logic [RAY_W-1:0] ray;
		for (int w = 0; w < 6; w++) begin
			ray[w*WORD_W +: WORD_W] = $random(seed);
		end
		return ray;
	endfunction

	// origin words sit three slots above their direction words
	function automatic logic [AXIS_W-1:0] expected_pair(input logic [RAY_W-1:0] ray,
			input axis_e axis);
		int org_word;
		int dir_word;
		org_word = 5 - int'(axis);
		dir_word = 2 - int'(axis);
		return {ray[org_word*WORD_W +: WORD_W], ray[dir_word*WORD_W +: WORD_W]};
	endfunction

	// which axis the returned pair belongs to, code 3 if none
	function automatic axis_e find_axis(input logic [AXIS_W-1:0] pair,
			input logic [RAY_W-1:0] ray);
		for (int a = 0; a < 3; a++) begin
			if (expected_pair(ray, axis_e'(a)) == pair) begin
				return axis_e'(a);
			end
		end
		return axis_e'(2'd3);
	endfunction

	function automatic axis_e next_axis(input axis_e axis);
		return (axis == AXIS_Z) ? AXIS_X : axis_e'(axis + 2'd1);
	endfunction

	task automatic report(input string what);
		errors++;
		$display("Error at %0t: %s", $time, what);
	endtask

	task automatic check_ray(input string name, input logic [RAY_W-1:0] got,
			input logic [RAY_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_pair(input string name, input logic [AXIS_W-1:0] got,
			input logic [AXIS_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_field(input string name, input logic [TAG_W-1:0] got,
			input logic [TAG_W-1:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
		end
	endtask

	task automatic check_axis(input string name, input axis_e got, input axis_e exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail at %0t: %s got %0d expected %0d", $time, name, got, exp);
		end
	endtask

	task automatic check_result(input int r, input exp_t e);
		logic [AXIS_W-1:0] pair;
		string port;
		port = (r < 2) ? $sformatf("trav%0d_out", r) : ((r == 2) ? "lcache_out" : "list_out");
		check_field({port, "_ray_id"}, TAG_W'(res_id[r]), TAG_W'(e.ray_id));
		if (r < 2) begin
			pair = {res_org[r], res_dir[r]};
			check_field({port, "_node_id"}, res_tag[r], e.tag);
			check_axis({port, "_axis"}, find_axis(pair, e.ray), e.axis);
			check_pair({port, "_axis_pair"}, pair, expected_pair(e.ray, e.axis));
		end else begin
			if (r == 2) begin
				check_field({port, "_tri_id"}, res_tag[r], e.tag);
			end
			check_ray({port, "_ray"}, res_ray[r], e.ray);
		end
	endtask

	// handshakes that happen on the coming rising edge
	task automatic sample_cycle();
		exp_t e;
		served = '0;
		if ($countones(req_ready) > 2) begin
			report("more than two request readies high in one cycle");
		end
		if (load_en && req_ready != '0) begin
			report("request ready high during a load cycle");
		end
		for (int r = 0; r < NUM_REQ; r++) begin
			if (out_valid[r] && out_ready[r]) begin
				if (exp_q[r].size() == 0) begin
					report($sformatf("requester %0d returned a result nobody asked for", r));
				end else begin
					check_result(r, exp_q[r].pop_front());
				end
			end
			if (req_valid[r] && req_ready[r]) begin
				e.ray_id = req_id[r];
				e.tag = req_tag[r];
				e.axis = req_axis[r];
				e.ray = ref_mem[req_id[r]];
				exp_q[r].push_back(e);
				served[r] = 1'b1;
			end
			if (exp_q[r].size() > LANE_DEPTH) begin
				report($sformatf("requester %0d accepted past its lane credit", r));
			end
		end
		if (load_en) begin
			ref_mem[load_addr] = load_data;
		end
	endtask

	task automatic step();
		#(PERIOD / 4);
		sample_cycle();
		@(negedge clk);
	endtask

	task automatic set_row(input int i, input logic load, input logic [NUM_REQ-1:0] valid,
			input int ray_id, input int tag, input axis_e axis,
			input logic [NUM_REQ-1:0] out_rdy, input int hold);
		rows[i].load = load;
		rows[i].valid = valid;
		rows[i].ray_id = RAY_ID_W'(ray_id);
		rows[i].tag = TAG_W'(tag);
		rows[i].axis = axis;
		rows[i].out_rdy = out_rdy;
		rows[i].hold = hold;
	endtask

	task automatic build_table();
		// all four contend, one axis per row
		set_row(0, 1'b0, 4'b1111, 10, 'h0100, AXIS_X, 4'hf, 0);
		set_row(1, 1'b0, 4'b1111, 100, 'h0200, AXIS_Y, 4'hf, 0);
		set_row(2, 1'b0, 4'b1111, 200, 'h0300, AXIS_Z, 4'hf, 0);
		set_row(3, 1'b0, 4'b0011, 508, 'h0400, AXIS_X, 4'hf, 0);
		set_row(4, 1'b0, 4'b0101, 33, 'h0500, AXIS_Z, 4'hf, 0);
		// trav0 result port stalled across three rows
		set_row(5, 1'b0, 4'b1111, 40, 'h0600, AXIS_Y, 4'b1110, 6);
		set_row(6, 1'b0, 4'b1111, 50, 'h0700, AXIS_X, 4'b1110, 6);
		set_row(7, 1'b0, 4'b0001, 60, 'h0800, AXIS_Z, 4'b1110, 6);
		set_row(8, 1'b0, 4'b1100, 300, 'h0900, AXIS_X, 4'b0011, 5);
		set_row(9, 1'b0, 4'b1111, 310, 'h0a00, AXIS_Y, 4'b0011, 5);
		// loads, then reads of the same ids
		set_row(10, 1'b1, 4'b1111, 77, 'h0b00, AXIS_Z, 4'hf, 0);
		set_row(11, 1'b0, 4'b1100, 75, 'h0c00, AXIS_X, 4'hf, 0);
		set_row(12, 1'b1, 4'b0000, 400, 'h0d00, AXIS_X, 4'hf, 0);
		set_row(13, 1'b0, 4'b1111, 400, 'h0e00, AXIS_Y, 4'hf, 0);
	endtask

	task automatic apply_row(input row_t row);
		int cycles;
		load_en = row.load;
		load_addr = row.ray_id;
		if (row.load) begin
			load_data = random_ray();
		end
		out_ready = row.out_rdy;
		for (int r = 0; r < NUM_REQ; r++) begin
			req_valid[r] = row.valid[r];
			req_id[r] = row.ray_id + RAY_ID_W'(r);
			req_tag[r] = row.tag + TAG_W'(r);
			req_axis[r] = (r == 1) ? next_axis(row.axis) : row.axis;
		end
		cycles = 0;
		do begin
			step();
			cycles++;
			load_en = 1'b0;
			req_valid = req_valid & ~served;
			if (cycles >= row.hold) begin
				out_ready = '1;
			end
		end while (req_valid != '0 || cycles < row.hold);
	endtask

	function automatic bit results_pending();
		for (int r = 0; r < NUM_REQ; r++) begin
			if (exp_q[r].size() != 0) begin
				return 1'b1;
			end
		end
		return 1'b0;
	endfunction

	initial begin
		seed = SEED;
		checks = 0;
		errors = 0;
		served = '0;
		req_valid = '0;
		out_ready = '0;
		load_en = 1'b0;
		load_addr = '0;
		load_data = '0;
		for (int r = 0; r < NUM_REQ; r++) begin
			req_id[r] = '0;
			req_tag[r] = '0;
			req_axis[r] = AXIS_X;
		end
		build_table();
		wait (arst_n === 1'b1);
		if (out_valid != '0) begin
			report("result valid high right after reset");
		end
		for (int i = 0; i < RAM_DEPTH; i++) begin
			load_en = 1'b1;
			load_addr = RAY_ID_W'(i);
			load_data = random_ray();
			step();
		end
		load_en = 1'b0;
		for (int i = 0; i < NUM_ROWS; i++) begin
			apply_row(rows[i]);
		end
		out_ready = '1;
		while (results_pending()) begin
			step();
		end
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout at %0t: a request or result never completed", $time);
		$display("Some tests failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- bench/tb_clock.sv
`default_nettype none

module tb_clock #(
	parameter int PERIOD = 100,
	parameter int RESET_CYCLES = 3
) (
	output logic clk,
	output logic arst_n
);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// release on a falling edge, clear of the rising edge
	initial begin
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
	end

endmodule

`default_nettype wire

//--- logic/ray_ram.sv
`default_nettype none

module ray_ram
	import raystore_pkg::*;
(
	input  logic                clk,
	input  logic [RAY_ID_W-1:0] addr_a,
	input  logic                we_a,
	input  logic [RAY_W-1:0]    wdata_a,
	output logic [RAY_W-1:0]    rd_a,
	input  logic [RAY_ID_W-1:0] addr_b,
	output logic [RAY_W-1:0]    rd_b
);

	logic [RAY_W-1:0] mem [RAM_DEPTH];

	// port a: write or read, never both
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= wdata_a;
		end else begin
			rd_a <= mem[addr_a];
		end
	end

	// port b is read only
	always_ff @(posedge clk) begin
		rd_b <= mem[addr_b];
	end

endmodule

`default_nettype wire

//--- logic/raystore.sv
`default_nettype none

module raystore
	import raystore_pkg::*;
(
	input  logic                 clk,
	input  logic                 arst_n,

	input  logic                 trav0_valid,
	output logic                 trav0_ready,
	input  logic [RAY_ID_W-1:0]  trav0_ray_id,
	input  logic [NODE_ID_W-1:0] trav0_node_id,
	input  axis_e                trav0_axis,

	input  logic                 trav1_valid,
	output logic                 trav1_ready,
	input  logic [RAY_ID_W-1:0]  trav1_ray_id,
	input  logic [NODE_ID_W-1:0] trav1_node_id,
	input  axis_e                trav1_axis,

	input  logic                 lcache_valid,
	output logic                 lcache_ready,
	input  logic [RAY_ID_W-1:0]  lcache_ray_id,
	input  logic [TRI_ID_W-1:0]  lcache_tri_id,

	input  logic                 list_valid,
	output logic                 list_ready,
	input  logic [RAY_ID_W-1:0]  list_ray_id,

	output logic                 trav0_out_valid,
	input  logic                 trav0_out_ready,
	output logic [RAY_ID_W-1:0]  trav0_out_ray_id,
	output logic [NODE_ID_W-1:0] trav0_out_node_id,
	output logic [WORD_W-1:0]    trav0_out_axis_origin,
	output logic [WORD_W-1:0]    trav0_out_axis_dir,

	output logic                 trav1_out_valid,
	input  logic                 trav1_out_ready,
	output logic [RAY_ID_W-1:0]  trav1_out_ray_id,
	output logic [NODE_ID_W-1:0] trav1_out_node_id,
	output logic [WORD_W-1:0]    trav1_out_axis_origin,
	output logic [WORD_W-1:0]    trav1_out_axis_dir,

	output logic                 lcache_out_valid,
	input  logic                 lcache_out_ready,
	output logic [RAY_ID_W-1:0]  lcache_out_ray_id,
	output logic [TRI_ID_W-1:0]  lcache_out_tri_id,
	output logic [RAY_W-1:0]     lcache_out_ray,

	output logic                 list_out_valid,
	input  logic                 list_out_ready,
	output logic [RAY_ID_W-1:0]  list_out_ray_id,
	output logic [RAY_W-1:0]     list_out_ray,

	input  logic                 load_en,
	input  logic [RAY_ID_W-1:0]  load_addr,
	input  logic [RAY_W-1:0]     load_data
);

	logic [NUM_REQ-1:0] req_valid;
	logic [NUM_REQ-1:0] lane_ready;
	logic [NUM_REQ-1:0] grant;
	logic [NUM_REQ-1:0] port_b;
	logic [RAY_ID_W-1:0] addr_a;
	logic [RAY_ID_W-1:0] addr_b;
	logic we_a;
	logic [RAY_W-1:0] rd_a;
	logic [RAY_W-1:0] rd_b;
	logic [RAY_W-1:0] trav0_ray;
	logic [RAY_W-1:0] trav1_ray;

	assign req_valid[REQ_TRAV0] = trav0_valid;
	assign req_valid[REQ_TRAV1] = trav1_valid;
	assign req_valid[REQ_LCACHE] = lcache_valid;
	assign req_valid[REQ_LIST] = list_valid;

	assign trav0_ready = grant[REQ_TRAV0];
	assign trav1_ready = grant[REQ_TRAV1];
	assign lcache_ready = grant[REQ_LCACHE];
	assign list_ready = grant[REQ_LIST];

	// traversal lanes return the axis pair in the low bits
	assign trav0_out_axis_origin = trav0_ray[AXIS_W-1:WORD_W];
	assign trav0_out_axis_dir = trav0_ray[WORD_W-1:0];
	assign trav1_out_axis_origin = trav1_ray[AXIS_W-1:WORD_W];
	assign trav1_out_axis_dir = trav1_ray[WORD_W-1:0];

	raystore_arb u_arb (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.lane_ready(lane_ready),
		.ray_id_trav0(trav0_ray_id),
		.ray_id_trav1(trav1_ray_id),
		.ray_id_lcache(lcache_ray_id),
		.ray_id_list(list_ray_id),
		.load_en(load_en),
		.load_addr(load_addr),
		.grant(grant),
		.port_b(port_b),
		.addr_a(addr_a),
		.addr_b(addr_b),
		.we_a(we_a)
	);

	ray_ram u_ram (
		.clk(clk),
		.addr_a(addr_a),
		.we_a(we_a),
		.wdata_a(load_data),
		.rd_a(rd_a),
		.addr_b(addr_b),
		.rd_b(rd_b)
	);

	raystore_lane #(.AXIS_SEL(1'b1), .META_W(NODE_ID_W)) u_lane_trav0 (
		.clk(clk),
		.arst_n(arst_n),
		.grant(grant[REQ_TRAV0]),
		.port_b(port_b[REQ_TRAV0]),
		.in_ray_id(trav0_ray_id),
		.in_meta(trav0_node_id),
		.in_axis(trav0_axis),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.lane_ready(lane_ready[REQ_TRAV0]),
		.out_valid(trav0_out_valid),
		.out_ready(trav0_out_ready),
		.out_ray_id(trav0_out_ray_id),
		.out_meta(trav0_out_node_id),
		.out_ray(trav0_ray)
	);

	raystore_lane #(.AXIS_SEL(1'b1), .META_W(NODE_ID_W)) u_lane_trav1 (
		.clk(clk),
		.arst_n(arst_n),
		.grant(grant[REQ_TRAV1]),
		.port_b(port_b[REQ_TRAV1]),
		.in_ray_id(trav1_ray_id),
		.in_meta(trav1_node_id),
		.in_axis(trav1_axis),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.lane_ready(lane_ready[REQ_TRAV1]),
		.out_valid(trav1_out_valid),
		.out_ready(trav1_out_ready),
		.out_ray_id(trav1_out_ray_id),
		.out_meta(trav1_out_node_id),
		.out_ray(trav1_ray)
	);

	raystore_lane #(.AXIS_SEL(1'b0), .META_W(TRI_ID_W)) u_lane_lcache (
		.clk(clk),
		.arst_n(arst_n),
		.grant(grant[REQ_LCACHE]),
		.port_b(port_b[REQ_LCACHE]),
		.in_ray_id(lcache_ray_id),
		.in_meta(lcache_tri_id),
		.in_axis(AXIS_X),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.lane_ready(lane_ready[REQ_LCACHE]),
		.out_valid(lcache_out_valid),
		.out_ready(lcache_out_ready),
		.out_ray_id(lcache_out_ray_id),
		.out_meta(lcache_out_tri_id),
		.out_ray(lcache_out_ray)
	);

	// list requests carry no tag
	raystore_lane #(.AXIS_SEL(1'b0), .META_W(1)) u_lane_list (
		.clk(clk),
		.arst_n(arst_n),
		.grant(grant[REQ_LIST]),
		.port_b(port_b[REQ_LIST]),
		.in_ray_id(list_ray_id),
		.in_meta(1'b0),
		.in_axis(AXIS_X),
		.rd_a(rd_a),
		.rd_b(rd_b),
		.lane_ready(lane_ready[REQ_LIST]),
		.out_valid(list_out_valid),
		.out_ready(list_out_ready),
		.out_ray_id(list_out_ray_id),
		.out_meta(),
		.out_ray(list_out_ray)
	);

endmodule

`default_nettype wire

//--- logic/raystore_arb.sv
`default_nettype none

module raystore_arb
	import raystore_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic [NUM_REQ-1:0]  req_valid,
	input  logic [NUM_REQ-1:0]  lane_ready,
	input  logic [RAY_ID_W-1:0] ray_id_trav0,
	input  logic [RAY_ID_W-1:0] ray_id_trav1,
	input  logic [RAY_ID_W-1:0] ray_id_lcache,
	input  logic [RAY_ID_W-1:0] ray_id_list,
	input  logic                load_en,
	input  logic [RAY_ID_W-1:0] load_addr,
	output logic [NUM_REQ-1:0]  grant,
	output logic [NUM_REQ-1:0]  port_b,
	output logic [RAY_ID_W-1:0] addr_a,
	output logic [RAY_ID_W-1:0] addr_b,
	output logic                we_a
);

	req_e ptr;
	req_e idx;
	req_e sel_a;
	req_e sel_b;
	logic found_a;
	logic found_b;
	logic [NUM_REQ-1:0] eligible;
	logic [RAY_ID_W-1:0] ray_id [NUM_REQ];

	assign ray_id[REQ_TRAV0] = ray_id_trav0;
	assign ray_id[REQ_TRAV1] = ray_id_trav1;
	assign ray_id[REQ_LCACHE] = ray_id_lcache;
	assign ray_id[REQ_LIST] = ray_id_list;

	assign eligible = req_valid & lane_ready;

	// walk upward from the pointer, first hit on port a, second on port b
	always_comb begin
		grant = '0;
		port_b = '0;
		sel_a = REQ_TRAV0;
		sel_b = REQ_TRAV0;
		found_a = 1'b0;
		found_b = 1'b0;
		idx = ptr;
		for (int k = 0; k < NUM_REQ; k++) begin
			idx = req_e'(ptr + 2'(k));
			if (eligible[idx] && !load_en) begin
				if (!found_a) begin
					found_a = 1'b1;
					sel_a = idx;
					grant[idx] = 1'b1;
				end else if (!found_b) begin
					found_b = 1'b1;
					sel_b = idx;
					grant[idx] = 1'b1;
					port_b[idx] = 1'b1;
				end
			end
		end
	end

	// a load takes port a for the whole cycle
	assign we_a = load_en;
	assign addr_a = load_en ? load_addr : ray_id[sel_a];
	assign addr_b = ray_id[sel_b];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ptr <= REQ_TRAV0;
		end else if (!load_en && |req_valid) begin
			ptr <= req_e'(ptr + 2'd1);
		end
	end

	// two memory ports, so never more than two reads per cycle
	a_two_grants: assert property (@(posedge clk) disable iff (!arst_n)
		$countones(grant) <= 2);

	a_no_grant_on_load: assert property (@(posedge clk) disable iff (!arst_n)
		load_en |-> grant == '0);

endmodule

`default_nettype wire

//--- logic/raystore_lane.sv
`default_nettype none

module raystore_lane
	import raystore_pkg::*;
#(
	parameter bit AXIS_SEL = 1'b0,
	parameter int META_W = 16
) (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                grant,
	input  logic                port_b,
	input  logic [RAY_ID_W-1:0] in_ray_id,
	input  logic [META_W-1:0]   in_meta,
	input  axis_e               in_axis,
	input  logic [RAY_W-1:0]    rd_a,
	input  logic [RAY_W-1:0]    rd_b,
	output logic                lane_ready,
	output logic                out_valid,
	input  logic                out_ready,
	output logic [RAY_ID_W-1:0] out_ray_id,
	output logic [META_W-1:0]   out_meta,
	output logic [RAY_W-1:0]    out_ray
);

	// request in flight through the memory
	logic inf_valid;
	logic inf_port_b;
	logic [RAY_ID_W-1:0] inf_ray_id;
	logic [META_W-1:0] inf_meta;
	axis_e inf_axis;

	logic [RAY_W-1:0] sel_ray;
	logic [RAY_W-1:0] push_ray;

	logic [RAY_ID_W-1:0] q_ray_id [LANE_DEPTH];
	logic [META_W-1:0] q_meta [LANE_DEPTH];
	logic [RAY_W-1:0] q_ray [LANE_DEPTH];
	logic [LANE_PTR_W-1:0] wr_ptr;
	logic [LANE_PTR_W-1:0] rd_ptr;
	logic [LANE_CNT_W-1:0] count;
	logic [LANE_CNT_W:0] used;
	logic pop;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			inf_valid <= 1'b0;
		end else begin
			inf_valid <= grant;
		end
	end

	always_ff @(posedge clk) begin
		if (grant) begin
			inf_port_b <= port_b;
			inf_ray_id <= in_ray_id;
			inf_meta <= in_meta;
			inf_axis <= in_axis;
		end
	end

	assign sel_ray = inf_port_b ? rd_b : rd_a;

	// traversal lanes keep only one axis, zero above it
	assign push_ray = AXIS_SEL ? {{(RAY_W - AXIS_W){1'b0}}, axis_pair(sel_ray, inf_axis)}
		: sel_ray;

	always_ff @(posedge clk) begin
		if (inf_valid) begin
			q_ray_id[wr_ptr] <= inf_ray_id;
			q_meta[wr_ptr] <= inf_meta;
			q_ray[wr_ptr] <= push_ray;
		end
	end

	assign out_valid = count != '0;
	assign pop = out_valid && out_ready;
	assign out_ray_id = q_ray_id[rd_ptr];
	assign out_meta = q_meta[rd_ptr];
	assign out_ray = q_ray[rd_ptr];

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (inf_valid) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({inf_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	// credit counts queued plus in flight entries
	assign used = {1'b0, count} + {{LANE_CNT_W{1'b0}}, inf_valid};
	assign lane_ready = used < (LANE_CNT_W + 1)'(LANE_DEPTH);

	a_legal_axis: assert property (@(posedge clk) disable iff (!arst_n)
		(grant && AXIS_SEL) |-> in_axis inside {AXIS_X, AXIS_Y, AXIS_Z});

	// a push into a full queue means the credit was wrong
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		(inf_valid && !pop) |-> count < (LANE_CNT_W)'(LANE_DEPTH));

endmodule

`default_nettype wire

//--- logic/raystore_pkg.sv
`default_nettype none

package raystore_pkg;

	localparam int WORD_W = 32;
	localparam int RAY_W = 6 * WORD_W;
	localparam int AXIS_W = 2 * WORD_W;
	localparam int RAY_ID_W = 9;
	localparam int RAM_DEPTH = 512;
	localparam int NODE_ID_W = 16;
	localparam int TRI_ID_W = 16;
	localparam int NUM_REQ = 4;

	localparam int LANE_DEPTH = 2;
	localparam int LANE_CNT_W = $clog2(LANE_DEPTH + 1);
	localparam int LANE_PTR_W = $clog2(LANE_DEPTH);

	// word slots inside a stored ray, origin on top
	localparam int W_ORG_X = 5;
	localparam int W_ORG_Y = 4;
	localparam int W_ORG_Z = 3;
	localparam int W_DIR_X = 2;
	localparam int W_DIR_Y = 1;
	localparam int W_DIR_Z = 0;

	// split axis of a traversal node, code 3 is illegal
	typedef enum logic [1:0] {
		AXIS_X = 2'd0,
		AXIS_Y = 2'd1,
		AXIS_Z = 2'd2
	} axis_e;

	// requester index, also the bit order of the request vector
	typedef enum logic [1:0] {
		REQ_TRAV0 = 2'd0,
		REQ_TRAV1 = 2'd1,
		REQ_LCACHE = 2'd2,
		REQ_LIST = 2'd3
	} req_e;

	// origin word above direction word for one axis
	function automatic logic [AXIS_W-1:0] axis_pair(input logic [RAY_W-1:0] ray,
			input axis_e axis);
		case (axis)
			AXIS_X: return {ray[W_ORG_X*WORD_W +: WORD_W], ray[W_DIR_X*WORD_W +: WORD_W]};
			AXIS_Y: return {ray[W_ORG_Y*WORD_W +: WORD_W], ray[W_DIR_Y*WORD_W +: WORD_W]};
			AXIS_Z: return {ray[W_ORG_Z*WORD_W +: WORD_W], ray[W_DIR_Z*WORD_W +: WORD_W]};
			default: return '0;
		endcase
	endfunction

endpackage

`default_nettype wire

//--- project.f
logic/raystore_pkg.sv
logic/ray_ram.sv
logic/raystore_arb.sv
logic/raystore_lane.sv
logic/raystore.sv
bench/tb_clock.sv
bench/raystore_tb.sv

//--- run.sh
#!/bin/sh
verilator --binary --assert -Wno-fatal --top-module raystore_tb -f project.f -o raystore_sim \
	&& ./obj_dir/raystore_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation failed"; exit 1; }
cat sim.log
grep -q "All tests passed" sim.log && exit 0 || exit 1
